//--- hw/rv_isa_pkg.sv
// RV32I only: fixed 32-bit widths, no compressed or M-extension encodings
package rv_isa_pkg;

        // ----------------------------------------
        // widths
        // ----------------------------------------
        localparam int XLEN       = 32;
        localparam int REG_ADDR_W = 5;
        localparam int SHAMT_W    = 5;
        localparam int FUNCT3_W   = 3;

        // ----------------------------------------
        // instruction field positions
        // ----------------------------------------
        localparam int FUNCT3_LSB = 12;
        localparam int RD_LSB     = 7;

        // set for OP (register-register), clear for OP-IMM
        localparam int OPCODE_RTYPE_BIT = 5;

        // SUB and SRA select
        localparam int ALT_BIT = 30;

        localparam int I_IMM_LSB = 20;
        localparam int I_IMM_W   = XLEN - I_IMM_LSB;
        localparam int U_IMM_LSB = 12;

        // link address step, no compressed instructions
        localparam int INSTR_BYTES = 4;

        // ----------------------------------------
        // types
        // ----------------------------------------
        typedef logic [XLEN - 1 : 0]       xlen_t;
        typedef logic [XLEN - 1 : 0]       pc_t;
        typedef logic [XLEN - 1 : 0]       instr_t;
        typedef logic [REG_ADDR_W - 1 : 0] reg_addr_t;
        typedef logic [SHAMT_W - 1 : 0]    shamt_t;
        typedef logic [FUNCT3_W - 1 : 0]   funct3_t;

        // OP / OP-IMM funct3
        typedef enum logic [FUNCT3_W - 1 : 0] {
                alu_add_sub = 3'b000,
                alu_sll     = 3'b001,
                alu_slt     = 3'b010,
                alu_sltu    = 3'b011,
                alu_xor     = 3'b100,
                alu_srl_sra = 3'b101,
                alu_or      = 3'b110,
                alu_and     = 3'b111
        } alu_op_e;

        // BRANCH funct3, 3'b010 and 3'b011 are reserved
        typedef enum logic [FUNCT3_W - 1 : 0] {
                branch_beq  = 3'b000,
                branch_bne  = 3'b001,
                branch_blt  = 3'b100,
                branch_bge  = 3'b101,
                branch_bltu = 3'b110,
                branch_bgeu = 3'b111
        } branch_op_e;

endpackage

//--- hw/exe_pkg.sv
// execute stage bundles; ctl flags arrive already decoded, one issue per cycle, no stall
package exe_pkg;

        // ----------------------------------------
        // decoded flags from the decode stage
        // ----------------------------------------
        typedef struct packed {
                logic load_y_from_imm;
                logic save_to_rd;
                logic lui;
                logic auipc;
                logic jal;
                logic jalr;
                logic branch;
        } exe_ctl_t;

        // stage register contents, ctl is zero on idle cycles
        typedef struct packed {
                logic               valid;
                rv_isa_pkg::xlen_t  x;
                rv_isa_pkg::xlen_t  y;
                rv_isa_pkg::instr_t ir;
                rv_isa_pkg::pc_t    pc;
                exe_ctl_t           ctl;
        } exe_latched_t;

        // ----------------------------------------
        // stage outputs
        // ----------------------------------------
        typedef struct packed {
                logic                  enable;
                rv_isa_pkg::reg_addr_t rd_addr;
                logic                  save_to_rd;
                rv_isa_pkg::xlen_t     data;
        } exe_result_t;

        typedef struct packed {
                logic            branch_taken;
                rv_isa_pkg::pc_t branch_addr;
                logic            jal;
                rv_isa_pkg::pc_t jal_addr;
                logic            jalr;
                rv_isa_pkg::pc_t jalr_addr;
        } exe_redirect_t;

endpackage

//--- hw/exe_stage_regs.sv
// captures every cycle; only valid and ctl depend on enable_i, so payload may hold junk when idle
`timescale 1ns/100ps

module exe_stage_regs (
        input  logic                     clk,
        input  logic                     reset_n,
        input  logic                     enable_i,
        input  rv_isa_pkg::instr_t       ir_i,
        input  rv_isa_pkg::pc_t          pc_i,
        input  rv_isa_pkg::xlen_t        rs1_i,
        input  rv_isa_pkg::xlen_t        rs2_i,
        input  exe_pkg::exe_ctl_t        ctl_i,
        output exe_pkg::exe_latched_t    latched_o
);

        import rv_isa_pkg::*;
        import exe_pkg::*;

        xlen_t    i_imm;
        xlen_t    y_next;
        exe_ctl_t ctl_gated;

        // ----------------------------------------
        // operand steering
        // ----------------------------------------

        // I-type immediate, sign extended from bit 31
        assign i_imm = {{(XLEN - I_IMM_W){ir_i[XLEN - 1]}}, ir_i[XLEN - 1 : I_IMM_LSB]};

        // OP-IMM and JALR style operand in place of rs2
        assign y_next = ctl_i.load_y_from_imm ? i_imm : rs2_i;

        // idle cycles must not leave a write or redirect behind
        assign ctl_gated = enable_i ? ctl_i : '0;

        // ----------------------------------------
        // stage register
        // ----------------------------------------
        always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                        latched_o <= '0;
                end else begin
                        latched_o.x     <= rs1_i;
                        latched_o.y     <= y_next;
                        latched_o.ir    <= ir_i;
                        latched_o.pc    <= pc_i;

                        // one cycle marker for the write-back enable
                        latched_o.valid <= enable_i;
                        latched_o.ctl   <= ctl_gated;
                end
        end

endmodule

//--- hw/exe_alu.sv
// combinational RV32I ALU; funct3 taken from the latched instruction, no M extension
`timescale 1ns/100ps

module exe_alu (
        input  exe_pkg::exe_latched_t latched_i,
        output rv_isa_pkg::xlen_t     alu_data_o
);

        import rv_isa_pkg::*;

        xlen_t   x;
        xlen_t   y;
        shamt_t  shamt;
        funct3_t funct3;
        alu_op_e op;
        logic    sub_sel;
        logic    sra_sel;

        assign x      = latched_i.x;
        assign y      = latched_i.y;
        assign shamt  = y[SHAMT_W - 1 : 0];
        assign funct3 = latched_i.ir[FUNCT3_LSB +: FUNCT3_W];
        assign op     = alu_op_e'(funct3);

        // ADDI has bit 30 as part of the immediate, so only OP may subtract
        assign sub_sel = latched_i.ir[OPCODE_RTYPE_BIT] & latched_i.ir[ALT_BIT];

        // shift immediates keep bit 30 clear for SRLI, so no format check
        assign sra_sel = latched_i.ir[ALT_BIT];

        // ----------------------------------------
        // operation select
        // ----------------------------------------
        always_comb begin
                case (op)
                        alu_add_sub: begin
                                alu_data_o = sub_sel ? (x - y) : (x + y);
                        end
                        alu_sll: begin
                                alu_data_o = x << shamt;
                        end
                        alu_slt: begin
                                alu_data_o = xlen_t'($signed(x) < $signed(y));
                        end
                        alu_sltu: begin
                                alu_data_o = xlen_t'(x < y);
                        end
                        alu_xor: begin
                                alu_data_o = x ^ y;
                        end
                        alu_srl_sra: begin
                                alu_data_o = sra_sel ? xlen_t'($signed(x) >>> shamt) : (x >> shamt);
                        end
                        alu_or: begin
                                alu_data_o = x | y;
                        end
                        alu_and: begin
                                alu_data_o = x & y;
                        end
                        default: begin
                                alu_data_o = '0;
                        end
                endcase
        end

endmodule

//--- hw/exe_flow_unit.sv
// branch and jump redirect; targets always computed, flags qualified by the gated ctl
`timescale 1ns/100ps

module exe_flow_unit (
        input  exe_pkg::exe_latched_t  latched_i,
        output exe_pkg::exe_redirect_t redirect_o
);

        import rv_isa_pkg::*;

        instr_t     ir;
        xlen_t      x;
        xlen_t      y;
        funct3_t    funct3;
        branch_op_e op;
        xlen_t      b_imm;
        xlen_t      j_imm;
        xlen_t      i_imm;
        xlen_t      jalr_sum;
        logic       eq;
        logic       lt_s;
        logic       lt_u;
        logic       cmp;

        assign ir     = latched_i.ir;
        assign x      = latched_i.x;
        assign y      = latched_i.y;
        assign funct3 = ir[FUNCT3_LSB +: FUNCT3_W];
        assign op     = branch_op_e'(funct3);

        // ----------------------------------------
        // immediates
        // ----------------------------------------
        assign b_imm = {{(XLEN - 12){ir[31]}}, ir[7], ir[30 : 25], ir[11 : 8], 1'b0};
        assign j_imm = {{(XLEN - 20){ir[31]}}, ir[19 : 12], ir[20], ir[30 : 21], 1'b0};
        assign i_imm = {{(XLEN - I_IMM_W){ir[XLEN - 1]}}, ir[XLEN - 1 : I_IMM_LSB]};

        // ----------------------------------------
        // branch compare
        // ----------------------------------------
        assign eq   = (x == y);
        assign lt_s = ($signed(x) < $signed(y));
        assign lt_u = (x < y);

        always_comb begin
                case (op)
                        branch_beq:  cmp = eq;
                        branch_bne:  cmp = ~eq;
                        branch_blt:  cmp = lt_s;
                        branch_bge:  cmp = ~lt_s;
                        branch_bltu: cmp = lt_u;
                        branch_bgeu: cmp = ~lt_u;
                        // reserved encodings fall through
                        default:     cmp = 1'b0;
                endcase
        end

        // ----------------------------------------
        // targets
        // ----------------------------------------
        assign jalr_sum = x + i_imm;

        assign redirect_o.branch_taken = latched_i.ctl.branch & cmp;
        assign redirect_o.branch_addr  = latched_i.pc + b_imm;
        assign redirect_o.jal          = latched_i.ctl.jal;
        assign redirect_o.jal_addr     = latched_i.pc + j_imm;
        assign redirect_o.jalr         = latched_i.ctl.jalr;

        // bit 0 dropped per the JALR definition
        assign redirect_o.jalr_addr    = {jalr_sum[XLEN - 1 : 1], 1'b0};

endmodule

//--- hw/exe_writeback.sv
// write-back select; the consumer must take result_o in the cycle enable is high
`timescale 1ns/100ps

module exe_writeback (
        input  exe_pkg::exe_latched_t latched_i,
        input  rv_isa_pkg::xlen_t     alu_data_i,
        output exe_pkg::exe_result_t  result_o
);

        import rv_isa_pkg::*;

        xlen_t lui_val;
        xlen_t auipc_val;
        xlen_t link_val;

        // ----------------------------------------
        // U-type and link values
        // ----------------------------------------
        assign lui_val   = {latched_i.ir[XLEN - 1 : U_IMM_LSB], {U_IMM_LSB{1'b0}}};
        assign auipc_val = lui_val + latched_i.pc;
        assign link_val  = latched_i.pc + xlen_t'(INSTR_BYTES);

        // ----------------------------------------
        // data select, first match wins
        // ----------------------------------------
        always_comb begin
                if (latched_i.ctl.lui) begin
                        result_o.data = lui_val;
                end else if (latched_i.ctl.auipc) begin
                        result_o.data = auipc_val;
                end else if (latched_i.ctl.jal | latched_i.ctl.jalr) begin
                        result_o.data = link_val;
                end else begin
                        result_o.data = alu_data_i;
                end
        end

        assign result_o.enable     = latched_i.valid;
        assign result_o.rd_addr    = latched_i.ir[RD_LSB +: REG_ADDR_W];
        assign result_o.save_to_rd = latched_i.ctl.save_to_rd;

endmodule

//--- hw/exe_unit.sv
// RV32I execute stage, one cycle issue to result, no back-pressure, no CSR or mul/div
`timescale 1ns/100ps

module exe_unit (
        input  logic                   clk,
        input  logic                   reset_n,
        input  logic                   enable_i,
        input  rv_isa_pkg::instr_t     ir_i,
        input  rv_isa_pkg::pc_t        pc_i,
        input  rv_isa_pkg::xlen_t      rs1_i,
        input  rv_isa_pkg::xlen_t      rs2_i,
        input  exe_pkg::exe_ctl_t      ctl_i,
        output exe_pkg::exe_result_t   result_o,
        output exe_pkg::exe_redirect_t redirect_o
);

        import rv_isa_pkg::*;
        import exe_pkg::*;

        exe_latched_t latched;
        xlen_t        alu_data;

        // ----------------------------------------
        // stage register
        // ----------------------------------------
        exe_stage_regs u_stage_regs (
                .clk       (clk),
                .reset_n   (reset_n),
                .enable_i  (enable_i),
                .ir_i      (ir_i),
                .pc_i      (pc_i),
                .rs1_i     (rs1_i),
                .rs2_i     (rs2_i),
                .ctl_i     (ctl_i),
                .latched_o (latched)
        );

        // ----------------------------------------
        // datapath, all combinational
        // ----------------------------------------
        exe_alu u_alu (
                .latched_i  (latched),
                .alu_data_o (alu_data)
        );

        exe_flow_unit u_flow_unit (
                .latched_i  (latched),
                .redirect_o (redirect_o)
        );

        exe_writeback u_writeback (
                .latched_i  (latched),
                .alu_data_i (alu_data),
                .result_o   (result_o)
        );

endmodule

//--- verification/exe_ref_model.svh
// expected values from the RV32I rules; assumes each issue was captured with enable_i high
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

        // one issued instruction as the testbench drove it
        typedef struct packed {
                instr_t   ir;
                pc_t      pc;
                xlen_t    rs1;
                xlen_t    rs2;
                exe_ctl_t ctl;
        } issue_t;

        // ----------------------------------------
        // immediates, sign extended by shifting
        // ----------------------------------------
        function automatic xlen_t imm_i(instr_t ir);
                return $signed(ir) >>> 20;
        endfunction

        function automatic xlen_t imm_b(instr_t ir);
                return $signed({ir[31], ir[7], ir[30:25], ir[11:8], 20'b0}) >>> 19;
        endfunction

        function automatic xlen_t imm_j(instr_t ir);
                return $signed({ir[31], ir[19:12], ir[20], ir[30:21], 12'b0}) >>> 11;
        endfunction

        function automatic xlen_t imm_u(instr_t ir);
                return {ir[31:12], 12'b0};
        endfunction

        // second operand as the stage picks it
        function automatic xlen_t operand_b(issue_t it);
                return it.ctl.load_y_from_imm ? imm_i(it.ir) : it.rs2;
        endfunction

        function automatic xlen_t alu_ref(instr_t ir, xlen_t a, xlen_t b);
                shamt_t sh;
                sh = b[4:0];
                case (ir[14:12])
                        3'd0: return (ir[5] && ir[30]) ? a - b : a + b;
                        3'd1: return a << sh;
                        3'd2: return {31'd0, $signed(a) < $signed(b)};
                        3'd3: return {31'd0, a < b};
                        3'd4: return a ^ b;
                        3'd5: return ir[30] ? xlen_t'($signed(a) >>> sh) : a >> sh;
                        3'd6: return a | b;
                        default: return a & b;
                endcase
        endfunction

        function automatic exe_result_t expected_result(issue_t it);
                exe_result_t r;
                r.enable     = 1'b1;
                r.rd_addr    = it.ir[11:7];
                r.save_to_rd = it.ctl.save_to_rd;
                if (it.ctl.lui) begin
                        r.data = imm_u(it.ir);
                end else if (it.ctl.auipc) begin
                        r.data = imm_u(it.ir) + it.pc;
                end else if (it.ctl.jal || it.ctl.jalr) begin
                        r.data = it.pc + 32'd4;
                end else begin
                        r.data = alu_ref(it.ir, it.rs1, operand_b(it));
                end
                return r;
        endfunction

        function automatic exe_redirect_t expected_redirect(issue_t it);
                exe_redirect_t r;
                xlen_t         a;
                xlen_t         b;
                xlen_t         sum;
                logic          hit;
                a = it.rs1;
                b = operand_b(it);
                case (it.ir[14:12])
                        3'd0: hit = (a == b);
                        3'd1: hit = (a != b);
                        3'd4: hit = ($signed(a) < $signed(b));
                        3'd5: hit = ($signed(a) >= $signed(b));
                        3'd6: hit = (a < b);
                        3'd7: hit = (a >= b);
                        // reserved funct3, never taken
                        default: hit = 1'b0;
                endcase
                sum = it.rs1 + imm_i(it.ir);
                r.branch_taken = it.ctl.branch && hit;
                r.branch_addr  = it.pc + imm_b(it.ir);
                r.jal          = it.ctl.jal;
                r.jal_addr     = it.pc + imm_j(it.ir);
                r.jalr         = it.ctl.jalr;
                r.jalr_addr    = sum & ~32'd1;
                return r;
        endfunction

`endif

//--- verification/tb_exe_unit.sv
// fixed-seed random run that expects exactly one result per issue one cycle later with no stall
`timescale 1ns/100ps

module tb_exe_unit;

        import rv_isa_pkg::*;
        import exe_pkg::*;

        `include "exe_ref_model.svh"

        localparam int          PERIOD       = 4;
        localparam int          RESET_CYCLES = 5;
        localparam logic [31:0] SEED         = 32'h4e9587bf;
        localparam int          N_ALU        = 320;
        localparam int          BR_PER_OP    = 24;
        localparam int          N_BRANCH     = 6 * BR_PER_OP + 3;
        localparam int          N_JUMP       = 40;
        localparam int          N_UPPER      = 40;
        localparam int          N_MIXED      = 120;
        localparam int          N_ISSUES     = N_ALU + N_BRANCH + N_JUMP + N_UPPER + N_MIXED;

        localparam logic [6:0] OPC_OP     = 7'b0110011;
        localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
        localparam logic [6:0] OPC_BRANCH = 7'b1100011;
        localparam logic [6:0] OPC_JAL    = 7'b1101111;
        localparam logic [6:0] OPC_JALR   = 7'b1100111;
        localparam logic [6:0] OPC_LUI    = 7'b0110111;
        localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

        logic          clk;
        logic          reset_n;
        logic          enable_i;
        instr_t        ir_i;
        pc_t           pc_i;
        xlen_t         rs1_i;
        xlen_t         rs2_i;
        exe_ctl_t      ctl_i;
        exe_result_t   result_o;
        exe_redirect_t redirect_o;

        // issues waiting for their result in issue order
        issue_t pending[$];
        issue_t head;
        int     n_checked = 0;

        // enable_i seen at the previous rising edge
        logic   issued_q = 1'b0;

        exe_unit i_dut (
                .clk        (clk),
                .reset_n    (reset_n),
                .enable_i   (enable_i),
                .ir_i       (ir_i),
                .pc_i       (pc_i),
                .rs1_i      (rs1_i),
                .rs2_i      (rs2_i),
                .ctl_i      (ctl_i),
                .result_o   (result_o),
                .redirect_o (redirect_o)
        );

        initial begin
                clk = 1'b0;
                forever #(PERIOD / 2) clk = ~clk;
        end

        // ----------------------------------------
        // failure and compare tasks
        // ----------------------------------------
        task automatic fail_run(string why);
                $display("%s", why);
                $display("SOME TESTS FAILED");
                $fatal(1, "run stopped on first error");
        endtask

        task automatic check_word(string field, xlen_t got, xlen_t exp);
                if (got !== exp) begin
                        fail_run($sformatf("MISMATCH at %0t: %s got %08h expected %08h",
                                           $time, field, got, exp));
                end
        endtask

        task automatic check_flag(string field, logic got, logic exp);
                if (got !== exp) begin
                        fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                           $time, field, got, exp));
                end
        endtask

        task automatic check_result(exe_result_t got, exe_result_t exp);
                check_flag("result enable", got.enable, exp.enable);
                check_word("rd_addr", xlen_t'(got.rd_addr), xlen_t'(exp.rd_addr));
                check_flag("save_to_rd", got.save_to_rd, exp.save_to_rd);
                check_word("data", got.data, exp.data);
        endtask

        task automatic check_redirect(exe_redirect_t got, exe_redirect_t exp);
                check_flag("branch_taken", got.branch_taken, exp.branch_taken);
                check_word("branch_addr", got.branch_addr, exp.branch_addr);
                check_flag("jal", got.jal, exp.jal);
                check_word("jal_addr", got.jal_addr, exp.jal_addr);
                check_flag("jalr", got.jalr, exp.jalr);
                check_word("jalr_addr", got.jalr_addr, exp.jalr_addr);
        endtask

        // nothing may be written or redirected without an issue
        task automatic check_quiet();
                check_flag("idle save_to_rd", result_o.save_to_rd, 1'b0);
                check_flag("idle branch_taken", redirect_o.branch_taken, 1'b0);
                check_flag("idle jal", redirect_o.jal, 1'b0);
                check_flag("idle jalr", redirect_o.jalr, 1'b0);
        endtask

        // ----------------------------------------
        // stimulus builders
        // ----------------------------------------
        function automatic pc_t random_pc();
                pc_t p;
                p = $urandom;
                p[1:0] = 2'b00;
                return p;
        endfunction

        function automatic issue_t make_alu(funct3_t f3);
                issue_t it;
                logic   rtype;
                rtype = 1'($urandom_range(1, 0));
                it.ir = $urandom;
                it.ir[6:0] = rtype ? OPC_OP : OPC_OP_IMM;
                it.ir[14:12] = f3;
                it.pc = random_pc();
                it.rs1 = $urandom;
                it.rs2 = ($urandom_range(3, 0) == 0) ? it.rs1 : $urandom;
                it.ctl = '0;
                it.ctl.load_y_from_imm = ~rtype;
                it.ctl.save_to_rd = 1'b1;
                return it;
        endfunction

        function automatic issue_t make_branch(funct3_t f3, logic equal, logic flag);
                issue_t it;
                it.ir = $urandom;
                it.ir[6:0] = OPC_BRANCH;
                it.ir[14:12] = f3;
                it.pc = random_pc();
                it.rs1 = $urandom;
                it.rs2 = equal ? it.rs1 : $urandom;
                it.ctl = '0;
                it.ctl.branch = flag;
                return it;
        endfunction

        function automatic issue_t make_jump(logic is_jalr);
                issue_t it;
                it.ir = $urandom;
                it.pc = random_pc();
                it.rs1 = $urandom;
                it.rs2 = $urandom;
                it.ctl = '0;
                it.ctl.save_to_rd = 1'b1;
                if (is_jalr) begin
                        it.ir[6:0] = OPC_JALR;
                        it.ir[14:12] = 3'b000;
                        it.ctl.jalr = 1'b1;
                        it.ctl.load_y_from_imm = 1'b1;
                end else begin
                        it.ir[6:0] = OPC_JAL;
                        it.ctl.jal = 1'b1;
                end
                return it;
        endfunction

        function automatic issue_t make_upper(logic is_lui);
                issue_t it;
                it.ir = $urandom;
                it.ir[6:0] = is_lui ? OPC_LUI : OPC_AUIPC;
                it.pc = random_pc();
                it.rs1 = $urandom;
                it.rs2 = $urandom;
                it.ctl = '0;
                it.ctl.save_to_rd = 1'b1;
                it.ctl.lui = is_lui;
                it.ctl.auipc = ~is_lui;
                return it;
        endfunction

        // reserved branch funct3 values included here
        function automatic issue_t make_any();
                case ($urandom_range(3, 0))
                        0: return make_alu(funct3_t'($urandom_range(7, 0)));
                        1: return make_branch(funct3_t'($urandom_range(7, 0)),
                                              1'($urandom_range(1, 0)), 1'b1);
                        2: return make_jump(1'($urandom_range(1, 0)));
                        default: return make_upper(1'($urandom_range(1, 0)));
                endcase
        endfunction

        // ----------------------------------------
        // drive on the falling edge
        // ----------------------------------------
        task automatic issue_instr(issue_t it);
                @(negedge clk);
                enable_i = 1'b1;
                ir_i     = it.ir;
                pc_i     = it.pc;
                rs1_i    = it.rs1;
                rs2_i    = it.rs2;
                ctl_i    = it.ctl;
                pending.push_back(it);
        endtask

        // junk payload and flags that must all be gated off
        task automatic idle_cycle();
                @(negedge clk);
                enable_i = 1'b0;
                ir_i     = $urandom;
                pc_i     = $urandom;
                rs1_i    = $urandom;
                rs2_i    = $urandom;
                ctl_i    = 7'($urandom_range(127, 0));
        endtask

        // outputs still show the issue captured one edge earlier
        always @(posedge clk) begin
                if (reset_n) begin
                        if (result_o.enable && pending.size() == 0) begin
                                fail_run("unexpected result: enable high with nothing issued");
                        end else if (issued_q) begin
                                head = pending.pop_front();
                                check_result(result_o, expected_result(head));
                                check_redirect(redirect_o, expected_redirect(head));
                                n_checked++;
                        end else begin
                                check_flag("idle enable", result_o.enable, 1'b0);
                                check_quiet();
                        end
                        issued_q = enable_i;
                end
        end

        initial begin
                #(RESET_CYCLES * PERIOD + N_ISSUES * PERIOD * 4);
                fail_run("timeout: the run did not finish in the expected time");
        end

        initial begin
                int i;
                int k;
                void'($urandom(SEED));
                enable_i = 1'b0;
                ir_i     = '0;
                pc_i     = '0;
                rs1_i    = '0;
                rs2_i    = '0;
                ctl_i    = '0;
                reset_n  = 1'b0;
                repeat (RESET_CYCLES) @(negedge clk);
                reset_n = 1'b1;

                // state right after reset
                @(negedge clk);
                check_flag("reset enable", result_o.enable, 1'b0);
                check_quiet();

                for (i = 0; i < N_ALU; i++) begin
                        issue_instr(make_alu(funct3_t'(i % 8)));
                end

                // beq bne blt bge bltu bgeu with every fourth using equal operands
                for (k = 0; k < 6; k++) begin
                        for (i = 0; i < BR_PER_OP; i++) begin
                                issue_instr(make_branch(funct3_t'(k < 2 ? k : k + 2),
                                                        (i % 4) == 0, 1'b1));
                        end
                end

                // compare succeeds with the flag clear
                issue_instr(make_branch(3'd0, 1'b1, 1'b0));
                issue_instr(make_branch(3'd5, 1'b1, 1'b0));
                issue_instr(make_branch(3'd7, 1'b1, 1'b0));

                for (i = 0; i < N_JUMP; i++) begin
                        issue_instr(make_jump(i[0]));
                end
                for (i = 0; i < N_UPPER; i++) begin
                        issue_instr(make_upper(i[0]));
                end

                // mixed traffic with idle gaps
                for (i = 0; i < N_MIXED; i++) begin
                        issue_instr(make_any());
                        repeat ($urandom_range(2, 0)) idle_cycle();
                end

                idle_cycle();
                while (pending.size() != 0) begin
                        idle_cycle();
                end
                repeat (2) idle_cycle();

                if (n_checked == N_ISSUES) begin
                        $display("ALL TESTS PASSED");
                        $finish;
                end else begin
                        fail_run($sformatf("got %0d results for %0d issues", n_checked, N_ISSUES));
                end
        end

endmodule

//--- files.f
+incdir+verification
hw/rv_isa_pkg.sv
hw/exe_pkg.sv
hw/exe_stage_regs.sv
hw/exe_alu.sv
hw/exe_flow_unit.sv
hw/exe_writeback.sv
hw/exe_unit.sv
verification/tb_exe_unit.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_exe_unit
RTL_TOP    = exe_unit
FILELIST   = files.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
